// File: hdl/cpu_on_board_config.svh
`ifndef CPU_ON_BOARD_CONFIG_SVH
`define CPU_ON_BOARD_CONFIG_SVH

// equal samples needed before the filtered ps/2 clock follows the pin
`define PS2_FILTER_LEN 8

// clock-high cycles before a partial frame is abandoned
`define PS2_IDLE_CYCLES 2000

// character queue entries
`define FIFO_DEPTH 8

// minimum spacing of console writes, in cycles
`define CONSOLE_GAP 64

// cycles per heartbeat led toggle
// a board build would raise this to get a visible blink
`define HEARTBEAT_CYCLES 1024

`endif

// File: hdl/ps2_pkg.sv
package ps2_pkg;

    // receiver fsm
    // error waits for a quiet bus before going back to idle
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP,
        RX_ERROR
    } rx_state_t;

    // one set-2 scan code byte
    typedef logic [7:0] scan_t;

    // key release marker, precedes the released code
    localparam scan_t BREAK_PREFIX = 8'hF0;

    // extended key marker
    localparam scan_t EXT_PREFIX = 8'hE0;

    // shift keys, tracked for upper case
    localparam scan_t LSHIFT = 8'h12;
    localparam scan_t RSHIFT = 8'h59;

endpackage

// File: hdl/console_pkg.sv
package console_pkg;

    // ascii character as sent to the console
    typedef logic [7:0] char_t;

    // key press counter on the green leds
    typedef logic [7:0] count_t;

    // no character, also the unmapped marker in the decoder
    localparam char_t CHAR_NUL = 8'h00;

    localparam char_t CHAR_SPACE = 8'h20;

    // enter sends carriage return
    localparam char_t CHAR_CR = 8'h0D;

    // distance from lower to upper case letters
    localparam char_t CHAR_UPPER_OFFSET = 8'h20;

endpackage

// File: hdl/ps2_rx.sv
`include "cpu_on_board_config.svh"

module ps2_rx (
    input  logic            CLOCK_50,
    input  logic            rst,
    input  logic            ps2_clk,
    input  logic            ps2_dat,
    output logic            code_valid,
    output ps2_pkg::scan_t  code,
    output logic            frame_error
);

    localparam int FILT_W = $clog2(`PS2_FILTER_LEN);
    localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES + 1);

    logic [1:0]          clk_sync;
    logic [1:0]          dat_sync;
    logic                filt_clk;
    logic                filt_prev;
    logic [FILT_W-1:0]   filt_cnt;
    logic [IDLE_W-1:0]   idle_cnt;
    logic                fall;
    logic                idle_done;
    logic [2:0]          bit_cnt;
    ps2_pkg::scan_t      shift_reg;
    ps2_pkg::rx_state_t  state;

    // two-flop synchronizers, both lines idle high
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    // glitch filter on the keyboard clock
    // level only changes after a full run of differing samples
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            filt_clk  <= 1'b1;
            filt_prev <= 1'b1;
            filt_cnt  <= '0;
        end else begin
            filt_prev <= filt_clk;
            if (clk_sync[1] == filt_clk) begin
                filt_cnt <= '0;
            end else if (filt_cnt == FILT_W'(`PS2_FILTER_LEN - 1)) begin
                filt_clk <= clk_sync[1];
                filt_cnt <= '0;
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    assign fall = filt_prev && !filt_clk;

    // clock-high time, saturates at the idle limit
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if (!filt_clk) begin
            idle_cnt <= '0;
        end else if (idle_cnt != IDLE_W'(`PS2_IDLE_CYCLES)) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign idle_done = (idle_cnt == IDLE_W'(`PS2_IDLE_CYCLES));

    // frame fsm, one step per filtered falling edge
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            state       <= ps2_pkg::RX_IDLE;
            bit_cnt     <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                ps2_pkg::RX_IDLE: begin
                    // start bit must be zero
                    if (fall) begin
                        if (!dat_sync[1]) begin
                            state   <= ps2_pkg::RX_DATA;
                            bit_cnt <= '0;
                        end else begin
                            state       <= ps2_pkg::RX_ERROR;
                            frame_error <= 1'b1;
                        end
                    end
                end
                ps2_pkg::RX_DATA: begin
                    if (idle_done) begin
                        state <= ps2_pkg::RX_IDLE;
                    end else if (fall) begin
                        // lsb first, shift in from the top
                        shift_reg <= {dat_sync[1], shift_reg[7:1]};
                        bit_cnt   <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ps2_pkg::RX_PARITY;
                        end
                    end
                end
                ps2_pkg::RX_PARITY: begin
                    if (idle_done) begin
                        state <= ps2_pkg::RX_IDLE;
                    end else if (fall) begin
                        // odd parity over data plus parity bit
                        if (^{shift_reg, dat_sync[1]}) begin
                            state <= ps2_pkg::RX_STOP;
                        end else begin
                            state       <= ps2_pkg::RX_ERROR;
                            frame_error <= 1'b1;
                        end
                    end
                end
                ps2_pkg::RX_STOP: begin
                    if (idle_done) begin
                        state <= ps2_pkg::RX_IDLE;
                    end else if (fall) begin
                        if (dat_sync[1]) begin
                            state      <= ps2_pkg::RX_IDLE;
                            code_valid <= 1'b1;
                        end else begin
                            state       <= ps2_pkg::RX_ERROR;
                            frame_error <= 1'b1;
                        end
                    end
                end
                default: begin
                    // wait out the rest of the bad frame
                    if (idle_done) begin
                        state <= ps2_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // shift register holds still from parity until the next start bit
    assign code = shift_reg;

    a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (rst)
        !(code_valid && frame_error));

    a_single_pulse: assert property (@(posedge CLOCK_50) disable iff (rst)
        (code_valid || frame_error) |=> !(code_valid || frame_error));

endmodule

// File: hdl/scan_decoder.sv
module scan_decoder (
    input  logic                CLOCK_50,
    input  logic                rst,
    input  logic                code_valid,
    input  ps2_pkg::scan_t      code,
    output logic                key_pressed,
    output logic                key_released,
    output console_pkg::char_t  ascii
);

    logic                break_pending;
    logic                ext_pending;
    logic                shift_held;
    logic                is_shift;
    console_pkg::char_t  mapped;
    console_pkg::char_t  shifted;

    // set-2 make code to lower case ascii, nul when unmapped
    function automatic console_pkg::char_t map_code(input ps2_pkg::scan_t sc);
        console_pkg::char_t c;
        case (sc)
            8'h1C: c = "a";
            8'h32: c = "b";
            8'h21: c = "c";
            8'h23: c = "d";
            8'h24: c = "e";
            8'h2B: c = "f";
            8'h34: c = "g";
            8'h33: c = "h";
            8'h43: c = "i";
            8'h3B: c = "j";
            8'h42: c = "k";
            8'h4B: c = "l";
            8'h3A: c = "m";
            8'h31: c = "n";
            8'h44: c = "o";
            8'h4D: c = "p";
            8'h15: c = "q";
            8'h2D: c = "r";
            8'h1B: c = "s";
            8'h2C: c = "t";
            8'h3C: c = "u";
            8'h2A: c = "v";
            8'h1D: c = "w";
            8'h22: c = "x";
            8'h35: c = "y";
            8'h1A: c = "z";
            8'h45: c = "0";
            8'h16: c = "1";
            8'h1E: c = "2";
            8'h26: c = "3";
            8'h25: c = "4";
            8'h2E: c = "5";
            8'h36: c = "6";
            8'h3D: c = "7";
            8'h3E: c = "8";
            8'h46: c = "9";
            8'h29: c = console_pkg::CHAR_SPACE;
            8'h5A: c = console_pkg::CHAR_CR;
            default: c = console_pkg::CHAR_NUL;
        endcase
        return c;
    endfunction

    assign mapped   = map_code(code);
    assign is_shift = (code == ps2_pkg::LSHIFT) || (code == ps2_pkg::RSHIFT);

    // letters only get upper case, digits stay as they are
    always_comb begin
        shifted = mapped;
        if (shift_held && (mapped >= "a") && (mapped <= "z")) begin
            shifted = mapped - console_pkg::CHAR_UPPER_OFFSET;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            break_pending <= 1'b0;
            ext_pending   <= 1'b0;
            shift_held    <= 1'b0;
            key_pressed   <= 1'b0;
            key_released  <= 1'b0;
        end else begin
            key_pressed  <= 1'b0;
            key_released <= 1'b0;
            if (code_valid) begin
                if (code == ps2_pkg::EXT_PREFIX) begin
                    ext_pending <= 1'b1;
                end else if (code == ps2_pkg::BREAK_PREFIX) begin
                    break_pending <= 1'b1;
                end else begin
                    // any real code ends the prefix sequence
                    break_pending <= 1'b0;
                    ext_pending   <= 1'b0;
                    if (ext_pending) begin
                        // extended keys dropped, make and break alike
                    end else if (break_pending) begin
                        key_released <= 1'b1;
                        if (is_shift) begin
                            shift_held <= 1'b0;
                        end
                    end else if (is_shift) begin
                        shift_held <= 1'b1;
                    end else if (mapped != console_pkg::CHAR_NUL) begin
                        key_pressed <= 1'b1;
                        ascii       <= shifted;
                    end
                end
            end
        end
    end

endmodule

// File: hdl/char_fifo.sv
`include "cpu_on_board_config.svh"

module char_fifo (
    input  logic                CLOCK_50,
    input  logic                rst,
    input  logic                push,
    input  console_pkg::char_t  push_data,
    input  logic                pop,
    output console_pkg::char_t  head,
    output logic                empty
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    console_pkg::char_t  mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;
    logic                do_push;
    logic                do_pop;

    assign full    = (count == CNT_W'(`FIFO_DEPTH));
    assign empty   = (count == '0);
    // push while full is lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // storage, no reset
    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // oldest entry, valid whenever not empty
    assign head = mem[rd_ptr];

    a_no_pop_empty: assert property (@(posedge CLOCK_50) disable iff (rst)
        pop |-> !empty);

endmodule

// File: hdl/console_pacer.sv
`include "cpu_on_board_config.svh"

module console_pacer (
    input  logic                CLOCK_50,
    input  logic                rst,
    input  logic                empty,
    input  console_pkg::char_t  head,
    output logic                pop,
    output logic                console_write,
    output console_pkg::char_t  console_data
);

    localparam int GAP_W = $clog2(`CONSOLE_GAP + 1);

    logic [GAP_W-1:0]  gap_cnt;
    logic              fire;

    // send when the spacing has run out and something is queued
    assign fire = (gap_cnt == '0) && !empty;

    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            gap_cnt       <= '0;
            pop           <= 1'b0;
            console_write <= 1'b0;
        end else begin
            // pop lands with the strobe, head is still the sent entry
            pop           <= fire;
            console_write <= fire;
            if (fire) begin
                gap_cnt <= GAP_W'(`CONSOLE_GAP);
            end else if (gap_cnt != '0) begin
                gap_cnt <= gap_cnt - 1'b1;
            end
        end
    end

    // character register, no reset
    always_ff @(posedge CLOCK_50) begin
        if (fire) begin
            console_data <= head;
        end
    end

    // single pulse, then quiet for the rest of the gap
    a_write_spacing: assert property (@(posedge CLOCK_50) disable iff (rst)
        console_write |=> !console_write [* (`CONSOLE_GAP - 1)]);

endmodule

// File: hdl/led_status.sv
`include "cpu_on_board_config.svh"

module led_status (
    input  logic                 CLOCK_50,
    input  logic                 rst,
    input  logic                 key_pressed,
    input  console_pkg::char_t   ascii,
    output console_pkg::count_t  ledg,
    output console_pkg::char_t   ledr7_0,
    output logic                 ledr9
);

    localparam int HB_W = $clog2(`HEARTBEAT_CYCLES);

    logic [HB_W-1:0]  hb_cnt;

    // press count wraps at 256, last character stays lit
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            ledg    <= '0;
            ledr7_0 <= '0;
        end else if (key_pressed) begin
            ledg    <= ledg + 1'b1;
            ledr7_0 <= ascii;
        end
    end

    // heartbeat prescaler
    always_ff @(posedge CLOCK_50) begin
        if (rst) begin
            hb_cnt <= '0;
            ledr9  <= 1'b0;
        end else if (hb_cnt == HB_W'(`HEARTBEAT_CYCLES - 1)) begin
            hb_cnt <= '0;
            ledr9  <= ~ledr9;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

endmodule

// File: hdl/cpu_on_board.sv
module cpu_on_board (
    input  logic                 CLOCK_50,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_dat,
    output console_pkg::count_t  ledg,
    output logic                 ledr9,
    output console_pkg::char_t   ledr7_0,
    output logic                 console_write,
    output console_pkg::char_t   console_data
);

    logic                code_valid;
    ps2_pkg::scan_t      code;
    logic                frame_error;
    logic                key_pressed;
    logic                key_released;
    console_pkg::char_t  ascii;
    console_pkg::char_t  head;
    logic                empty;
    logic                pop;

    // keyboard frames to scan codes
    ps2_rx ps2_rx_i (
        .CLOCK_50    (CLOCK_50),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_dat     (ps2_dat),
        .code_valid  (code_valid),
        .code        (code),
        .frame_error (frame_error)
    );

    // scan codes to ascii key events
    scan_decoder scan_decoder_i (
        .CLOCK_50     (CLOCK_50),
        .rst          (rst),
        .code_valid   (code_valid),
        .code         (code),
        .key_pressed  (key_pressed),
        .key_released (key_released),
        .ascii        (ascii)
    );

    // burst buffer ahead of the paced console
    char_fifo char_fifo_i (
        .CLOCK_50  (CLOCK_50),
        .rst       (rst),
        .push      (key_pressed),
        .push_data (ascii),
        .pop       (pop),
        .head      (head),
        .empty     (empty)
    );

    console_pacer console_pacer_i (
        .CLOCK_50      (CLOCK_50),
        .rst           (rst),
        .empty         (empty),
        .head          (head),
        .pop           (pop),
        .console_write (console_write),
        .console_data  (console_data)
    );

    led_status led_status_i (
        .CLOCK_50    (CLOCK_50),
        .rst         (rst),
        .key_pressed (key_pressed),
        .ascii       (ascii),
        .ledg        (ledg),
        .ledr7_0     (ledr7_0),
        .ledr9       (ledr9)
    );

endmodule

// File: sim/tb_cpu_on_board.sv
`include "cpu_on_board_config.svh"

module tb_cpu_on_board;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ENTRIES = 8;
    localparam int MAX_FRAMES  = 12;
    localparam int MAX_CHARS   = 6;
    localparam int HALF_CYCLES = 40;
    localparam int BIT_CYCLES  = 2 * HALF_CYCLES;
    localparam int MAX_GAP     = 200;
    localparam int SETTLE      = `CONSOLE_GAP + 16;
    localparam int BURST_IDX   = 6;
    // every entry at its longest, then queue drain, idle recovery and slack
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * MAX_FRAMES * (11 * BIT_CYCLES + MAX_GAP)
        + `FIFO_DEPTH * `CONSOLE_GAP + NUM_ENTRIES * SETTLE + `PS2_IDLE_CYCLES + 5000;

    logic                 CLOCK_50 = 1'b0;
    logic                 rst;
    logic                 ps2_clk;
    logic                 ps2_dat;
    console_pkg::count_t  ledg;
    logic                 ledr9;
    console_pkg::char_t   ledr7_0;
    logic                 console_write;
    console_pkg::char_t   console_data;

    // stimulus table, first frame and first char at index 0
    int                   n_codes [NUM_ENTRIES];
    ps2_pkg::scan_t       code_tab [NUM_ENTRIES][MAX_FRAMES];
    bit                   bad_tab [NUM_ENTRIES][MAX_FRAMES];
    int                   n_chars [NUM_ENTRIES];
    console_pkg::char_t   exp_tab [NUM_ENTRIES][MAX_CHARS];

    console_pkg::char_t   rx_q[$];
    int                   wr_cycles[$];
    int                   hb_cycles[$];
    logic                 hb_prev;
    int                   cycle_cnt = 0;

    cpu_on_board dut_i (
        .CLOCK_50      (CLOCK_50),
        .rst           (rst),
        .ps2_clk       (ps2_clk),
        .ps2_dat       (ps2_dat),
        .ledg          (ledg),
        .ledr9         (ledr9),
        .ledr7_0       (ledr7_0),
        .console_write (console_write),
        .console_data  (console_data)
    );

    // 50 MHz
    always #10 CLOCK_50 = ~CLOCK_50;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    // run limit
    always @(posedge CLOCK_50) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            abort_run("timeout: expected console characters never arrived");
        end
    end

    // console monitor, sampled mid-cycle
    always @(negedge CLOCK_50) begin
        if (!rst && console_write) begin
            rx_q.push_back(console_data);
            wr_cycles.push_back(cycle_cnt);
        end
    end

    // heartbeat edge log
    always @(negedge CLOCK_50) begin
        if (!rst && ledr9 !== hb_prev) begin
            hb_cycles.push_back(cycle_cnt);
        end
        hb_prev <= ledr9;
    end

    task automatic check_char(input string name, input console_pkg::char_t exp,
                              input console_pkg::char_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input console_pkg::count_t exp,
                               input console_pkg::count_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // wait n rising edges, then step past them for input changes
    task automatic tick(input int n);
        if (n > 0) begin
            repeat (n) @(posedge CLOCK_50);
            #2;
        end
    endtask

    // keyboard model: start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input ps2_pkg::scan_t data, input bit bad_parity);
        logic [10:0] bits;
        logic        par;
        int          i;
        par  = (~^data) ^ bad_parity;
        bits = {1'b1, par, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            // data settles while the clock is high
            ps2_dat = bits[i];
            tick(HALF_CYCLES);
            ps2_clk = 1'b0;
            tick(HALF_CYCLES);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        tick(HALF_CYCLES);
    endtask

    // packed lists are right aligned, first item most significant
    task automatic load_entry(input int idx, input int n,
                              input logic [8*MAX_FRAMES-1:0] codes,
                              input logic [MAX_FRAMES-1:0] bad, input int nc,
                              input logic [8*MAX_CHARS-1:0] chars);
        int k;
        n_codes[idx] = n;
        n_chars[idx] = nc;
        for (k = 0; k < n; k++) begin
            code_tab[idx][k] = codes[8*(n-1-k) +: 8];
            bad_tab[idx][k]  = bad[k];
        end
        for (k = 0; k < nc; k++) begin
            exp_tab[idx][k] = chars[8*(nc-1-k) +: 8];
        end
    endtask

    // burst entry: five shuffled letters, make codes only
    task automatic fill_burst();
        ps2_pkg::scan_t     pool_code [8];
        console_pkg::char_t pool_char [8];
        ps2_pkg::scan_t     tc;
        console_pkg::char_t tch;
        int                 i;
        int                 j;
        pool_code = '{8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h3B, 8'h42, 8'h4B, 8'h24};
        pool_char = '{"a", "s", "d", "f", "j", "k", "l", "e"};
        for (i = 7; i > 0; i--) begin
            j = $urandom % (i + 1);
            tc = pool_code[i];
            pool_code[i] = pool_code[j];
            pool_code[j] = tc;
            tch = pool_char[i];
            pool_char[i] = pool_char[j];
            pool_char[j] = tch;
        end
        n_codes[BURST_IDX] = 5;
        n_chars[BURST_IDX] = 5;
        for (i = 0; i < 5; i++) begin
            code_tab[BURST_IDX][i] = pool_code[i];
            bad_tab[BURST_IDX][i]  = 1'b0;
            exp_tab[BURST_IDX][i]  = pool_char[i];
        end
    endtask

    initial begin
        int                 e;
        int                 k;
        int                 exp_total;
        console_pkg::char_t last_char;
        console_pkg::char_t exp_q[$];
        rst       = 1'b1;
        ps2_clk   = 1'b1;
        ps2_dat   = 1'b1;
        hb_prev   = 1'b0;
        exp_total = 0;
        last_char = '0;
        void'($urandom(77));

        // letter, digit, space plus enter
        load_entry(0, 3, {8'h1C, 8'hF0, 8'h1C}, '0, 1, "a");
        load_entry(1, 3, {8'h2E, 8'hF0, 8'h2E}, '0, 1, "5");
        load_entry(2, 6, {8'h29, 8'hF0, 8'h29, 8'h5A, 8'hF0, 8'h5A}, '0, 2, {8'h20, 8'h0D});
        // left shift, then right shift, each released mid entry
        load_entry(3, 9, {8'h12, 8'h32, 8'hF0, 8'h32, 8'hF0, 8'h12, 8'h32, 8'hF0, 8'h32},
                   '0, 2, "Bb");
        load_entry(4, 9, {8'h59, 8'h21, 8'hF0, 8'h21, 8'hF0, 8'h59, 8'h21, 8'hF0, 8'h21},
                   '0, 2, "Cc");
        // parity error on the first frame only
        load_entry(5, 4, {8'h1C, 8'h23, 8'hF0, 8'h23}, 12'h001, 1, "d");
        fill_burst();
        // extended up arrow, esc and f1 give nothing
        load_entry(7, 11, {8'hE0, 8'h75, 8'hE0, 8'hF0, 8'h75, 8'h76, 8'hF0, 8'h76,
                           8'h05, 8'hF0, 8'h05}, '0, 0, '0);

        tick(16);
        rst = 1'b0;
        tick(1);
        check_count("ledg", '0, ledg);
        check_char("ledr7_0", '0, ledr7_0);
        if (console_write !== 1'b0 || ledr9 !== 1'b0) begin
            abort_run("console_write or ledr9 not low after reset");
        end

        for (e = 0; e < NUM_ENTRIES; e++) begin
            for (k = 0; k < n_codes[e]; k++) begin
                send_frame(code_tab[e][k], bad_tab[e][k]);
                // a bad frame needs the idle time before the receiver rearms
                if (bad_tab[e][k]) begin
                    tick(`PS2_IDLE_CYCLES + 100);
                end else if (e != BURST_IDX) begin
                    // burst frames go back to back
                    tick($urandom % (MAX_GAP + 1));
                end
            end
            for (k = 0; k < n_chars[e]; k++) begin
                exp_q.push_back(exp_tab[e][k]);
                last_char = exp_tab[e][k];
            end
            exp_total += n_chars[e];
            while (rx_q.size() < exp_total) begin
                @(posedge CLOCK_50);
            end
            // room for a stray extra character to show up
            tick(SETTLE);
            if (rx_q.size() != exp_total) begin
                abort_run($sformatf("entry %0d gave %0d console characters, wanted %0d",
                                    e, rx_q.size(), exp_total));
            end
            for (k = exp_total - n_chars[e]; k < exp_total; k++) begin
                check_char("console_data", exp_q[k], rx_q[k]);
            end
            check_count("ledg", console_pkg::count_t'(exp_total), ledg);
            check_char("ledr7_0", last_char, ledr7_0);
        end

        // console spacing over the whole run
        for (k = 1; k < wr_cycles.size(); k++) begin
            if (wr_cycles[k] - wr_cycles[k-1] < `CONSOLE_GAP) begin
                abort_run($sformatf("console writes only %0d cycles apart",
                                    wr_cycles[k] - wr_cycles[k-1]));
            end
        end

        // heartbeat period
        if (hb_cycles.size() < 3) begin
            abort_run("heartbeat led did not toggle");
        end
        for (k = 1; k < hb_cycles.size(); k++) begin
            if (hb_cycles[k] - hb_cycles[k-1] != `HEARTBEAT_CYCLES) begin
                abort_run($sformatf("ledr9 toggled after %0d cycles",
                                    hb_cycles[k] - hb_cycles[k-1]));
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: cpu_on_board.f
+incdir+hdl
hdl/ps2_pkg.sv
hdl/console_pkg.sv
hdl/ps2_rx.sv
hdl/scan_decoder.sv
hdl/char_fifo.sv
hdl/console_pacer.sv
hdl/led_status.sv
hdl/cpu_on_board.sv
sim/tb_cpu_on_board.sv
